//--- rtl/rvCoreSettings.svh
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// data and address width
`define XLEN 32

// architectural register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

//--- rtl/rvCorePkg.sv
`default_nettype none

package rvCorePkg;

    // one instruction word, field layouts per format
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFmt_t;

    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFmt_t;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } sFmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } bFmt_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uFmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jFmt_t;

    typedef union packed {
        rFmt_t r;
        iFmt_t i;
        sFmt_t s;
        bFmt_t b;
        uFmt_t u;
        jFmt_t j;
    } instrWord_u;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_PASS_B
    } aluOp_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } immFmt_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_JAL, BR_JALR
    } branchKind_e;

endpackage

`default_nettype wire

//--- rtl/rvCtrlIf.sv
`default_nettype none

interface rvCtrlIf;
    import rvCorePkg::*;

    immFmt_e     immFmt;
    aluOp_e      aluOp;
    logic        aluSrcImm;   // operand b from immediate
    logic        aluSrcPc;    // operand a from pc, auipc
    logic        regWrite;
    logic        memWrite;
    logic        memToReg;    // write back load data
    branchKind_e branchKind;

    modport decode (
        output immFmt, aluOp, aluSrcImm, aluSrcPc,
        output regWrite, memWrite, memToReg, branchKind
    );

    modport datapath (
        input immFmt, aluOp, aluSrcImm, aluSrcPc,
        input regWrite, memWrite, memToReg, branchKind
    );

endinterface

`default_nettype wire

//--- rtl/rvDecoder.sv
`default_nettype none

module rvDecoder (
    input  rvCorePkg::instrWord_u instruction,
    rvCtrlIf.decode               ctrl
);
    import rvCorePkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcode_e'(instruction.r.opcode);
    assign funct3 = instruction.r.funct3;
    assign funct7 = instruction.r.funct7;

    always_comb begin
        // anything not matched below stays a no-op
        ctrl.immFmt     = IMM_NONE;
        ctrl.aluOp      = ALU_ADD;
        ctrl.aluSrcImm  = 1'b0;
        ctrl.aluSrcPc   = 1'b0;
        ctrl.regWrite   = 1'b0;
        ctrl.memWrite   = 1'b0;
        ctrl.memToReg   = 1'b0;
        ctrl.branchKind = BR_NONE;

        case (opcode)
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin // lw
                    ctrl.immFmt    = IMM_I;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.regWrite  = 1'b1;
                    ctrl.memToReg  = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                if (funct3 == 3'b000) begin // addi
                    ctrl.immFmt    = IMM_I;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.regWrite  = 1'b1;
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin // sw
                    ctrl.immFmt    = IMM_S;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.memWrite  = 1'b1;
                end
            end
            OPC_OP: begin
                case ({funct7, funct3})
                    10'b0000000_000: begin
                        ctrl.aluOp    = ALU_ADD;
                        ctrl.regWrite = 1'b1;
                    end
                    10'b0100000_000: begin
                        ctrl.aluOp    = ALU_SUB;
                        ctrl.regWrite = 1'b1;
                    end
                    10'b0000000_111: begin
                        ctrl.aluOp    = ALU_AND;
                        ctrl.regWrite = 1'b1;
                    end
                    10'b0000000_010: begin
                        ctrl.aluOp    = ALU_SLT;
                        ctrl.regWrite = 1'b1;
                    end
                    default: ;
                endcase
            end
            OPC_BRANCH: begin
                ctrl.immFmt = IMM_B;
                case (funct3)
                    3'b000: begin
                        ctrl.aluOp      = ALU_SUB; // taken on zero
                        ctrl.branchKind = BR_BEQ;
                    end
                    3'b001: begin
                        ctrl.aluOp      = ALU_SUB;
                        ctrl.branchKind = BR_BNE;
                    end
                    3'b100: begin
                        ctrl.aluOp      = ALU_SLT;
                        ctrl.branchKind = BR_BLT;
                    end
                    default: ctrl.immFmt = IMM_NONE;
                endcase
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    ctrl.immFmt     = IMM_I;
                    ctrl.aluSrcImm  = 1'b1; // alu forms rs1 + imm target
                    ctrl.regWrite   = 1'b1;
                    ctrl.branchKind = BR_JALR;
                end
            end
            OPC_JAL: begin
                ctrl.immFmt     = IMM_J;
                ctrl.regWrite   = 1'b1;
                ctrl.branchKind = BR_JAL;
            end
            OPC_LUI: begin
                ctrl.immFmt    = IMM_U;
                ctrl.aluOp     = ALU_PASS_B;
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.immFmt    = IMM_U;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluSrcPc  = 1'b1;
                ctrl.regWrite  = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/rvRegFile.sv
`default_nettype none

`include "rvCoreSettings.svh"

module rvRegFile (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`REG_ADDR_W-1:0] readAddrA,
    input  logic [`REG_ADDR_W-1:0] readAddrB,
    input  logic [`REG_ADDR_W-1:0] writeAddr,
    input  logic [`XLEN-1:0]       writeData,
    input  logic                   writeEn,
    output logic [`XLEN-1:0]       readDataA,
    output logic [`XLEN-1:0]       readDataB
);

    logic [`XLEN-1:0] regs [1:`REG_COUNT-1]; // x0 has no storage

    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

    always_ff @(posedge clk) begin
        if (!reset && writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

`default_nettype wire

//--- rtl/rvImmGen.sv
`default_nettype none

`include "rvCoreSettings.svh"

module rvImmGen (
    input  rvCorePkg::instrWord_u instruction,
    input  rvCorePkg::immFmt_e    fmt,
    output logic [`XLEN-1:0]      imm
);
    import rvCorePkg::*;

    always_comb begin
        case (fmt)
            IMM_I: begin
                imm = {{(`XLEN-12){instruction.i.imm11_0[11]}}, instruction.i.imm11_0};
            end
            IMM_S: begin
                imm = {{(`XLEN-12){instruction.s.imm11_5[6]}},
                       instruction.s.imm11_5,
                       instruction.s.imm4_0};
            end
            IMM_B: begin
                imm = {{(`XLEN-13){instruction.b.imm12}},
                       instruction.b.imm12,
                       instruction.b.imm11,
                       instruction.b.imm10_5,
                       instruction.b.imm4_1,
                       1'b0}; // halfword offset
            end
            IMM_U: begin
                imm = {instruction.u.imm31_12, 12'b0};
            end
            IMM_J: begin
                imm = {{(`XLEN-21){instruction.j.imm20}},
                       instruction.j.imm20,
                       instruction.j.imm19_12,
                       instruction.j.imm11,
                       instruction.j.imm10_1,
                       1'b0};
            end
            default: imm = '0; // r-type and no-op
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/rvAlu.sv
`default_nettype none

`include "rvCoreSettings.svh"

module rvAlu (
    input  logic [`XLEN-1:0] srcA,
    input  logic [`XLEN-1:0] srcB,
    input  rvCorePkg::aluOp_e op,
    output logic [`XLEN-1:0] result,
    output logic             zero
);
    import rvCorePkg::*;

    logic lessThan;

    assign lessThan = $signed(srcA) < $signed(srcB);

    always_comb begin
        case (op)
            ALU_ADD:    result = srcA + srcB;
            ALU_SUB:    result = srcA - srcB;
            ALU_AND:    result = srcA & srcB;
            ALU_OR:     result = srcA | srcB;
            ALU_SLT:    result = {{(`XLEN-1){1'b0}}, lessThan};
            ALU_PASS_B: result = srcB; // lui
            default:    result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- rtl/rvCore.sv
`default_nettype none

`include "rvCoreSettings.svh"

module rvCore (
    input  logic             clk,
    input  logic             reset,
    input  logic [`XLEN-1:0] instruction,
    input  logic [`XLEN-1:0] dataFromMem,
    output logic [`XLEN-1:0] PC,
    output logic             WE,
    output logic [`XLEN-1:0] addressToMem,
    output logic [`XLEN-1:0] dataToMem
);
    import rvCorePkg::*;

    instrWord_u       instrWord;
    logic [`XLEN-1:0] pcReg;
    logic [`XLEN-1:0] nextPc;
    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] pcPlusImm;
    logic [`XLEN-1:0] jalrTarget;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] aluA;
    logic [`XLEN-1:0] aluB;
    logic [`XLEN-1:0] aluResult;
    logic             aluZero;
    logic [`XLEN-1:0] writeBack;
    logic             branchTaken;
    logic             isJump;

    assign instrWord = instruction;

    rvCtrlIf ctrl ();

    rvDecoder decoder (
        .instruction (instrWord),
        .ctrl        (ctrl)
    );

    rvRegFile regFile (
        .clk       (clk),
        .reset     (reset),
        .readAddrA (instrWord.r.rs1),
        .readAddrB (instrWord.r.rs2),
        .writeAddr (instrWord.r.rd),
        .writeData (writeBack),
        .writeEn   (ctrl.regWrite),
        .readDataA (rs1Data),
        .readDataB (rs2Data)
    );

    rvImmGen immGen (
        .instruction (instrWord),
        .fmt         (ctrl.immFmt),
        .imm         (imm)
    );

    assign aluA = ctrl.aluSrcPc ? pcReg : rs1Data;
    assign aluB = ctrl.aluSrcImm ? imm : rs2Data;

    rvAlu alu (
        .srcA   (aluA),
        .srcB   (aluB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    assign pcPlus4    = pcReg + `XLEN'(4);
    assign pcPlusImm  = pcReg + imm;
    assign jalrTarget = {aluResult[`XLEN-1:1], 1'b0}; // rs1 + imm, bit 0 cleared
    assign isJump     = (ctrl.branchKind == BR_JAL) || (ctrl.branchKind == BR_JALR);

    always_comb begin
        case (ctrl.branchKind)
            BR_BEQ:  branchTaken = aluZero;
            BR_BNE:  branchTaken = !aluZero;
            BR_BLT:  branchTaken = aluResult[0]; // slt result
            BR_JAL:  branchTaken = 1'b1;
            default: branchTaken = 1'b0;
        endcase
    end

    always_comb begin
        if (ctrl.branchKind == BR_JALR) begin
            nextPc = jalrTarget;
        end else if (branchTaken) begin
            nextPc = pcPlusImm;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_comb begin
        if (ctrl.memToReg) begin
            writeBack = dataFromMem;
        end else if (isJump) begin
            writeBack = pcPlus4; // link address
        end else begin
            writeBack = aluResult;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pcReg <= `RESET_PC;
        end else begin
            pcReg <= nextPc;
        end
    end

    assign PC           = pcReg;
    assign WE           = ctrl.memWrite && !reset;
    assign addressToMem = aluResult;
    assign dataToMem    = rs2Data;

    // branch and jump targets from imm gen and alu keep fetch aligned
    assert property (@(posedge clk) disable iff (reset) PC[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- verif/rvMemModel.sv
`default_nettype none

`include "rvCoreSettings.svh"

module rvMemModel (
    input  logic             clk,
    input  logic [`XLEN-1:0] PC,
    input  logic             WE,
    input  logic [`XLEN-1:0] addressToMem,
    input  logic [`XLEN-1:0] dataToMem,
    input  int               storeIdx,
    output logic [`XLEN-1:0] instruction,
    output logic [`XLEN-1:0] dataFromMem,
    output logic [`XLEN-1:0] expAddr,
    output logic [`XLEN-1:0] expData,
    output int               storeCount,
    output int               progLen,
    output logic [`XLEN-1:0] loopPc,
    output logic [`XLEN-1:0] jalrPc,
    output logic [`XLEN-1:0] jalrTarget
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [`XLEN-1:0] BASE = 32'h0000_0100; // x10, store window
    localparam logic [`XLEN-1:0] NOP  = 32'h0000_0013;

    logic [`XLEN-1:0] rom [0:63];
    logic [`XLEN-1:0] ram [0:127];
    logic [`XLEN-1:0] expAddrTab [0:15];
    logic [`XLEN-1:0] expDataTab [0:15];
    int               pcIdx;

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] encR(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(int imm, int rs1, int f3, int rd, int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] encS(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011}; // sw
    endfunction

    function automatic logic [31:0] encB(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] encU(int imm20, int rd, int op);
        return {imm20[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] encJ(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] pcNow();
        return 32'(pcIdx) << 2;
    endfunction

    task automatic emit(input logic [31:0] word);
        rom[pcIdx] = word;
        pcIdx++;
    endtask

    task automatic storeAndExpect(input int offset, input logic [31:0] data, input int rs2);
        expAddrTab[storeCount] = BASE + 32'(offset);
        expDataTab[storeCount] = data;
        storeCount++;
        emit(encS(offset, rs2, 10));
    endtask

    task automatic poisonStore();
        emit(encS(44, 31, 10)); // x31 holds the poison word
    endtask

    task automatic takenBranch(input int f3, input int rs1, input int rs2);
        emit(encB(8, rs2, rs1, f3));
        poisonStore();
    endtask

    task automatic fallThroughBranch(input int f3, input int rs1, input int rs2);
        emit(encB(8, rs2, rs1, f3)); // target is the poison store
        emit(encJ(8, 0));
        poisonStore();
    endtask

    initial begin
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] c;
        r1 = 32'd6;
        r2 = 32'hFFFF_FFFD; // -3
        pcIdx = 0;
        storeCount = 0;
        for (int i = 0; i < 64; i++) begin
            rom[i] = NOP;
        end
        for (int i = 0; i < 128; i++) begin
            ram[i] <= lcgNext(32'd20 + 32'(i));
        end
        expAddrTab[storeCount] = 32'h0000_0040;
        expDataTab[storeCount] = 32'h0;
        storeCount++;
        emit(encS(64, 0, 0)); // sw x0, 64(x0) sits on the reset vector
        emit(encI(256, 0, 0, 10, 'h13));
        emit(encU('hDEADC, 31, 'h37));
        emit(encI(-273, 31, 0, 31, 'h13)); // poison 0xdeadbeef
        emit(encI(6, 0, 0, 1, 'h13));
        emit(encI(-3, 0, 0, 2, 'h13));
        emit(encR(0, 2, 1, 0, 3));
        storeAndExpect(0, r1 + r2, 3);
        emit(encR('h20, 2, 1, 0, 4));
        storeAndExpect(4, r1 - r2, 4);
        emit(encR(0, 2, 1, 7, 5));
        storeAndExpect(8, r1 & r2, 5);
        emit(encR(0, 1, 2, 2, 6)); // slt x6, x2, x1
        storeAndExpect(12, {31'b0, $signed(r2) < $signed(r1)}, 6);
        emit(encR(0, 2, 1, 2, 7));
        storeAndExpect(16, {31'b0, $signed(r1) < $signed(r2)}, 7);
        emit(encU('h12345, 8, 'h37));
        storeAndExpect(20, 32'h1234_5000, 8);
        emit(encI(7, 1, 0, 0, 'h13)); // write to x0 is dropped
        storeAndExpect(24, 32'h0, 0);
        emit(encI(0, 0, 2, 9, 'h03)); // lw x9, 0(x0)
        storeAndExpect(28, lcgNext(32'd20), 9);
        takenBranch(0, 1, 1);
        fallThroughBranch(0, 1, 2);
        takenBranch(1, 1, 2);
        fallThroughBranch(1, 1, 1);
        takenBranch(4, 2, 1);
        fallThroughBranch(4, 1, 2);
        c = pcNow();
        emit(encJ(8, 12));
        poisonStore();
        storeAndExpect(32, c + 32'd4, 12);
        c = pcNow();
        emit(encU(1, 13, 'h17)); // auipc x13, 1
        storeAndExpect(36, c + 32'h1000, 13);
        c = pcNow();
        emit(encU(0, 14, 'h17));
        jalrPc = pcNow();
        jalrTarget = (c + 32'd13) & ~32'd1; // odd sum, bit 0 dropped
        emit(encI(13, 14, 0, 15, 'h67));
        poisonStore();
        storeAndExpect(40, jalrPc + 32'd4, 15);
        loopPc = pcNow();
        emit(encJ(0, 0));
        progLen = pcIdx;
    end

    assign instruction = $isunknown(PC) ? NOP : rom[PC[7:2]];
    assign dataFromMem = $isunknown(addressToMem) ? '0 : ram[addressToMem[8:2]];
    assign expAddr     = (storeIdx < storeCount) ? expAddrTab[storeIdx[3:0]] : '0;
    assign expData     = (storeIdx < storeCount) ? expDataTab[storeIdx[3:0]] : '0;

    always @(posedge clk) begin
        if (WE) begin
            ram[addressToMem[8:2]] <= dataToMem;
        end
    end

endmodule

`default_nettype wire

//--- verif/rvCoreTb.sv
`default_nettype none

`include "rvCoreSettings.svh"

module rvCoreTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int               RESET_CYCLES = 10;
    localparam logic [`XLEN-1:0] POISON       = 32'hDEAD_BEEF;

    logic             clk;
    logic             reset;
    logic [`XLEN-1:0] instruction;
    logic [`XLEN-1:0] dataFromMem;
    logic [`XLEN-1:0] PC;
    logic             WE;
    logic [`XLEN-1:0] addressToMem;
    logic [`XLEN-1:0] dataToMem;
    logic [`XLEN-1:0] expAddr;
    logic [`XLEN-1:0] expData;
    logic [`XLEN-1:0] loopPc;
    logic [`XLEN-1:0] jalrPc;
    logic [`XLEN-1:0] jalrTarget;
    logic [`XLEN-1:0] prevPc;
    logic             controlFlow;
    int               storeIdx;
    int               storeCount;
    int               progLen;
    int               cycle = 0;

    rvCore uut (
        .clk          (clk),
        .reset        (reset),
        .instruction  (instruction),
        .dataFromMem  (dataFromMem),
        .PC           (PC),
        .WE           (WE),
        .addressToMem (addressToMem),
        .dataToMem    (dataToMem)
    );

    rvMemModel mem (
        .clk          (clk),
        .PC           (PC),
        .WE           (WE),
        .addressToMem (addressToMem),
        .dataToMem    (dataToMem),
        .storeIdx     (storeIdx),
        .instruction  (instruction),
        .dataFromMem  (dataFromMem),
        .expAddr      (expAddr),
        .expData      (expData),
        .storeCount   (storeCount),
        .progLen      (progLen),
        .loopPc       (loopPc),
        .jalrPc       (jalrPc),
        .jalrTarget   (jalrTarget)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // branch, jal and jalr opcodes
    assign controlFlow = instruction[6:0] inside {7'b1100011, 7'b1100111, 7'b1101111};

    always @(posedge clk) begin
        cycle  <= cycle + 1;
        prevPc <= PC;
        if (reset) begin
            storeIdx <= 0;
        end else if (WE) begin
            storeIdx <= storeIdx + 1;
        end
    end

    task automatic failRun();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // first edge loads the reset vector
    assert property (@(posedge clk) (reset && cycle > 0) |-> (PC == `RESET_PC && !WE))
        else begin
            $display("[ERROR] PC expected %h got %h, WE expected 0 got %h in reset",
                     `RESET_PC, $sampled(PC), $sampled(WE));
            failRun();
        end

    assert property (@(posedge clk) $fell(reset) |-> PC == `RESET_PC)
        else begin
            $display("[ERROR] PC expected %h got %h after reset", `RESET_PC, $sampled(PC));
            failRun();
        end

    assert property (@(posedge clk) disable iff (reset) !controlFlow |=> PC == prevPc + 32'd4)
        else begin
            $display("[ERROR] PC expected %h got %h", $sampled(prevPc) + 32'd4, $sampled(PC));
            failRun();
        end

    assert property (@(posedge clk) disable iff (reset) WE |-> storeIdx < storeCount)
        else begin
            $display("unexpected store beyond the %0d expected ones, to address %h",
                     storeCount, $sampled(addressToMem));
            failRun();
        end

    assert property (@(posedge clk) disable iff (reset) WE |-> addressToMem == expAddr)
        else begin
            $display("[ERROR] addressToMem expected %h got %h", $sampled(expAddr),
                     $sampled(addressToMem));
            failRun();
        end

    assert property (@(posedge clk) disable iff (reset) WE |-> dataToMem == expData)
        else begin
            $display("[ERROR] dataToMem expected %h got %h", $sampled(expData),
                     $sampled(dataToMem));
            failRun();
        end

    // a wrong-path store reached
    assert property (@(posedge clk) disable iff (reset) !(WE && dataToMem == POISON))
        else begin
            $display("[ERROR] dataToMem got poison %h at address %h", $sampled(dataToMem),
                     $sampled(addressToMem));
            failRun();
        end

    assert property (@(posedge clk) disable iff (reset) PC == jalrPc |=> PC == jalrTarget)
        else begin
            $display("[ERROR] PC expected %h got %h after jalr", jalrTarget, $sampled(PC));
            failRun();
        end

    assert property (@(posedge clk) disable iff (reset) storeIdx == storeCount |-> PC == loopPc)
        else begin
            $display("[ERROR] PC expected %h got %h in final loop", loopPc, $sampled(PC));
            failRun();
        end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
        while (storeIdx != storeCount && cycle < RESET_CYCLES + 4 * progLen) begin
            @(posedge clk);
            #1;
        end
        if (storeIdx == storeCount) begin
            repeat (2) begin // pc held at the self loop
                @(posedge clk);
                #1;
            end
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("timeout after %0d cycles with %0d of %0d stores seen",
                     cycle, storeIdx, storeCount);
            failRun();
        end
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+rtl
rtl/rvCorePkg.sv
rtl/rvCtrlIf.sv
rtl/rvDecoder.sv
rtl/rvRegFile.sv
rtl/rvImmGen.sv
rtl/rvAlu.sv
rtl/rvCore.sv
verif/rvMemModel.sv
verif/rvCoreTb.sv

//--- run.sh
#!/bin/sh
set -e

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f flist.f --top-module rvCoreTb -o rvCoreSim

status=0
./obj_dir/rvCoreSim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    exit 0
fi
echo "simulation exit status $status"
exit 1
